//--- logic/ntm_cosh_pkg.sv
/* Vector cosh shared definitions */

`default_nettype none

package ntm_cosh_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int data_width  = 16;
  localparam int frac_bits   = 12;
  localparam int acc_width   = 32;
  localparam int prod_width  = 48;
  localparam int vec_depth   = 16;
  localparam int index_width = 4;
  localparam int addr_width  = 8;

  // Series constants, one in Q4.12 and the x^4 divisor
  localparam logic [acc_width-1:0] fx_one     = acc_width'(1 << frac_bits);
  localparam logic [acc_width-1:0] fourth_div = acc_width'(24);

  // Largest legal vector length
  localparam logic [data_width-1:0] size_max = data_width'(vec_depth);

  //////////////////////////////
  // Register map
  //////////////////////////////

  localparam logic [addr_width-1:0] reg_ctrl   = 8'h00;
  localparam logic [addr_width-1:0] reg_status = 8'h04;
  localparam logic [addr_width-1:0] reg_modulo = 8'h08;
  localparam logic [addr_width-1:0] reg_size   = 8'h0C;
  localparam logic [addr_width-1:0] in_base    = 8'h40;
  localparam logic [addr_width-1:0] out_base   = 8'h80;

  //////////////////////////////
  // Types
  //////////////////////////////

  // Host request, APB setup and access phases
  typedef struct packed {
    logic                  sel;
    logic                  enable;
    logic                  write;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
  } apb_req_t;

  // One buffer write port
  typedef struct packed {
    logic                   en;
    logic [index_width-1:0] index;
    logic [data_width-1:0]  data;
  } buf_wr_t;

  typedef enum logic [1:0] {
    seq_idle,
    seq_fetch,
    seq_issue,
    seq_wait
  } seq_state_e;

  typedef enum logic [2:0] {
    cosh_idle,
    cosh_square,
    cosh_fourth,
    cosh_sum,
    cosh_reduce,
    cosh_done
  } cosh_state_e;

endpackage

`default_nettype wire

//--- logic/ntm_scalar_cosh_function.sv
/* Scalar cosh series unit */

`timescale 1ns/1ps
`default_nettype none

module ntm_scalar_cosh_function (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                start,
  output logic                                ready,
  input  logic [ntm_cosh_pkg::data_width-1:0] modulo_in,
  input  logic [ntm_cosh_pkg::data_width-1:0] data_in,
  output logic [ntm_cosh_pkg::data_width-1:0] data_out
);

  ntm_cosh_pkg::cosh_state_e state;
  logic [4:0]                cnt;

  // Operands and partial terms
  logic [ntm_cosh_pkg::data_width-1:0] x;
  logic [ntm_cosh_pkg::data_width-1:0] m;
  logic [ntm_cosh_pkg::acc_width-1:0]  t;
  logic [ntm_cosh_pkg::acc_width-1:0]  q;
  logic [ntm_cosh_pkg::acc_width-1:0]  y;
  logic [ntm_cosh_pkg::acc_width-1:0]  dividend;
  logic [ntm_cosh_pkg::data_width-1:0] rem;

  logic [ntm_cosh_pkg::prod_width-1:0] x_sq;
  logic [ntm_cosh_pkg::prod_width-1:0] t_sq;

  // One restoring step, remainder always below the modulus
  function automatic logic [ntm_cosh_pkg::data_width-1:0] mod_step(
    input logic [ntm_cosh_pkg::data_width-1:0] r,
    input logic                                b,
    input logic [ntm_cosh_pkg::data_width-1:0] d
  );
    logic [ntm_cosh_pkg::data_width:0] s;
    s = {r, b};
    if (s >= {1'b0, d}) begin
      s = s - {1'b0, d};
    end
    return s[ntm_cosh_pkg::data_width-1:0];
  endfunction

  //////////////////////////////
  // Series terms
  //////////////////////////////

  // Full products in the 48-bit context
  assign x_sq = x * x;
  assign t_sq = t * t;

  // 1 + x^2/2 + x^4/24 in Q4.12
  assign y = ntm_cosh_pkg::fx_one + (t >> 1) + q;

  assign ready    = state == ntm_cosh_pkg::cosh_done;
  assign data_out = rem;

  //////////////////////////////
  // Step control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ntm_cosh_pkg::cosh_idle;
      cnt   <= '0;
    end else begin
      case (state)
        ntm_cosh_pkg::cosh_idle: begin
          if (start) begin
            state <= ntm_cosh_pkg::cosh_square;
          end
        end
        ntm_cosh_pkg::cosh_square: state <= ntm_cosh_pkg::cosh_fourth;
        ntm_cosh_pkg::cosh_fourth: state <= ntm_cosh_pkg::cosh_sum;
        ntm_cosh_pkg::cosh_sum: begin
          // First reduction step rides along with the sum
          cnt   <= 5'd1;
          state <= ntm_cosh_pkg::cosh_reduce;
        end
        ntm_cosh_pkg::cosh_reduce: begin
          cnt <= cnt + 1'b1;
          // Last of 32 steps
          if (&cnt) begin
            state <= ntm_cosh_pkg::cosh_done;
          end
        end
        ntm_cosh_pkg::cosh_done: state <= ntm_cosh_pkg::cosh_idle;
        default: state <= ntm_cosh_pkg::cosh_idle;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    case (state)
      ntm_cosh_pkg::cosh_idle: begin
        if (start) begin
          x <= data_in;
          m <= modulo_in;
        end
      end
      ntm_cosh_pkg::cosh_square: begin
        t <= x_sq[ntm_cosh_pkg::frac_bits +: ntm_cosh_pkg::acc_width];
      end
      ntm_cosh_pkg::cosh_fourth: begin
        q <= t_sq[ntm_cosh_pkg::frac_bits +: ntm_cosh_pkg::acc_width]
             / ntm_cosh_pkg::fourth_div;
      end
      ntm_cosh_pkg::cosh_sum: begin
        rem      <= mod_step('0, y[ntm_cosh_pkg::acc_width-1], m);
        dividend <= y << 1;
      end
      ntm_cosh_pkg::cosh_reduce: begin
        rem      <= mod_step(rem, dividend[ntm_cosh_pkg::acc_width-1], m);
        dividend <= dividend << 1;
      end
      default: ;
    endcase
  end

  // Register block refuses a zero modulus
  assert property (@(posedge CLK) disable iff (RST)
    start |-> modulo_in != '0);

endmodule

`default_nettype wire

//--- logic/ntm_vector_buffer.sv
/* Input and result buffers */

`timescale 1ns/1ps
`default_nettype none

module ntm_vector_buffer (
  input  logic                                 CLK,
  input  ntm_cosh_pkg::buf_wr_t                in_wr,
  input  logic [ntm_cosh_pkg::index_width-1:0] in_rd_index,
  output logic [ntm_cosh_pkg::data_width-1:0]  in_rd_data,
  input  ntm_cosh_pkg::buf_wr_t                out_wr,
  input  logic [ntm_cosh_pkg::index_width-1:0] out_rd_index,
  output logic [ntm_cosh_pkg::data_width-1:0]  out_rd_data
);

  // Port 0 input elements, port 1 results
  ntm_cosh_pkg::buf_wr_t                wr_port  [2];
  logic [ntm_cosh_pkg::index_width-1:0] rd_index [2];
  logic [ntm_cosh_pkg::data_width-1:0]  rd_data  [2];

  assign wr_port[0]  = in_wr;
  assign wr_port[1]  = out_wr;
  assign rd_index[0] = in_rd_index;
  assign rd_index[1] = out_rd_index;
  assign in_rd_data  = rd_data[0];
  assign out_rd_data = rd_data[1];

  //////////////////////////////
  // RAMs
  //////////////////////////////

  for (genvar b = 0; b < 2; b++) begin : g_ram
    logic [ntm_cosh_pkg::data_width-1:0] mem [ntm_cosh_pkg::vec_depth];
    logic [ntm_cosh_pkg::data_width-1:0] q;

    // Registered read, old data on a same-address write
    always_ff @(posedge CLK) begin
      if (wr_port[b].en) begin
        mem[wr_port[b].index] <= wr_port[b].data;
      end
      q <= mem[rd_index[b]];
    end

    assign rd_data[b] = q;
  end

endmodule

`default_nettype wire

//--- logic/ntm_vector_cosh_function.sv
/* Vector cosh sequencer */

`timescale 1ns/1ps
`default_nettype none

module ntm_vector_cosh_function (
  input  logic                                 CLK,
  input  logic                                 RST,
  input  logic                                 start,
  input  logic [ntm_cosh_pkg::data_width-1:0]  modulo,
  input  logic [ntm_cosh_pkg::index_width:0]   size,
  output logic                                 busy,
  output logic                                 done,
  output logic [ntm_cosh_pkg::index_width-1:0] in_index,
  input  logic [ntm_cosh_pkg::data_width-1:0]  in_data,
  output ntm_cosh_pkg::buf_wr_t                out_wr
);

  ntm_cosh_pkg::seq_state_e             state;
  logic [ntm_cosh_pkg::index_width-1:0] idx;
  logic                                 last;
  logic                                 start_scalar;
  logic                                 ready_scalar;
  logic [ntm_cosh_pkg::data_width-1:0]  data_out_scalar;

  assign busy     = state != ntm_cosh_pkg::seq_idle;
  assign in_index = idx;
  assign last     = {1'b0, idx} == (size - 1'b1);

  // Element and modulus stay put until ready, index does not move
  assign start_scalar = state == ntm_cosh_pkg::seq_issue;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= ntm_cosh_pkg::seq_idle;
      idx    <= '0;
      done   <= 1'b0;
      out_wr <= '0;
    end else begin
      done      <= 1'b0;
      out_wr.en <= 1'b0;
      case (state)
        ntm_cosh_pkg::seq_idle: begin
          if (start) begin
            idx   <= '0;
            state <= ntm_cosh_pkg::seq_fetch;
          end
        end
        ntm_cosh_pkg::seq_fetch: begin
          // Writeback cycle of the previous element
          if (out_wr.en) begin
            if (last) begin
              done  <= 1'b1;
              state <= ntm_cosh_pkg::seq_idle;
            end else begin
              idx <= idx + 1'b1;
            end
          end else begin
            state <= ntm_cosh_pkg::seq_issue;
          end
        end
        ntm_cosh_pkg::seq_issue: begin
          state <= ntm_cosh_pkg::seq_wait;
        end
        ntm_cosh_pkg::seq_wait: begin
          if (ready_scalar) begin
            out_wr.en    <= 1'b1;
            out_wr.index <= idx;
            out_wr.data  <= data_out_scalar;
            state        <= ntm_cosh_pkg::seq_fetch;
          end
        end
        default: state <= ntm_cosh_pkg::seq_idle;
      endcase
    end
  end

  ntm_scalar_cosh_function scalar_cosh_inst (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start_scalar),
    .ready     (ready_scalar),
    .modulo_in (modulo),
    .data_in   (in_data),
    .data_out  (data_out_scalar)
  );

  // The unit drops starts outside idle, so a restart would miss this
  assert property (@(posedge CLK) disable iff (RST)
    start_scalar |-> ##35 ready_scalar);

endmodule

`default_nettype wire

//--- logic/ntm_apb_regs.sv
/* APB register block */

`timescale 1ns/1ps
`default_nettype none

module ntm_apb_regs (
  input  logic                                    CLK,
  input  logic                                    RST,
  input  ntm_cosh_pkg::apb_req_t                  apb_req,
  output logic [ntm_cosh_pkg::data_width-1:0]     prdata,
  output logic                                    pready,
  output logic                                    pslverr,
  output ntm_cosh_pkg::buf_wr_t                   host_in_wr,
  output logic [ntm_cosh_pkg::index_width-1:0]    host_out_index,
  input  logic [ntm_cosh_pkg::data_width-1:0]     host_out_data,
  output logic                                    start,
  output logic [ntm_cosh_pkg::data_width-1:0]     modulo,
  output logic [ntm_cosh_pkg::index_width:0]      size,
  input  logic                                    busy,
  input  logic                                    done
);

  logic access, wr_access;
  logic is_ctrl, is_status, is_modulo, is_size, hit_in, hit_out, aligned;
  logic mapped, bad_write, write_ok;
  logic done_flag;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  // Second cycle of every transfer
  assign access    = apb_req.sel && apb_req.enable;
  assign wr_access = access && apb_req.write;

  assign is_ctrl   = apb_req.addr == ntm_cosh_pkg::reg_ctrl;
  assign is_status = apb_req.addr == ntm_cosh_pkg::reg_status;
  assign is_modulo = apb_req.addr == ntm_cosh_pkg::reg_modulo;
  assign is_size   = apb_req.addr == ntm_cosh_pkg::reg_size;

  // Buffer windows, 16 words each
  assign aligned = apb_req.addr[1:0] == 2'b00;
  assign hit_in  = aligned && (apb_req.addr[7:6] == ntm_cosh_pkg::in_base[7:6]);
  assign hit_out = aligned && (apb_req.addr[7:6] == ntm_cosh_pkg::out_base[7:6]);

  assign mapped = is_ctrl || is_status || is_modulo || is_size || hit_in || hit_out;

  // Illegal values, or a run would be disturbed
  assign bad_write = (is_modulo && apb_req.wdata == '0)
                  || (is_size && (apb_req.wdata == '0
                                  || apb_req.wdata > ntm_cosh_pkg::size_max))
                  || (busy && (is_modulo || is_size || hit_in))
                  || (busy && is_ctrl && apb_req.wdata[0]);

  assign pslverr  = access && (!mapped || (apb_req.write && bad_write));
  assign write_ok = wr_access && mapped && !bad_write;
  assign pready   = 1'b1;

  //////////////////////////////
  // Buffer access
  //////////////////////////////

  assign host_in_wr.en    = write_ok && hit_in;
  assign host_in_wr.index = apb_req.addr[ntm_cosh_pkg::index_width+1:2];
  assign host_in_wr.data  = apb_req.wdata;

  // RAM samples this in setup, word is back for the access phase
  assign host_out_index = apb_req.addr[ntm_cosh_pkg::index_width+1:2];

  assign start = write_ok && is_ctrl && apb_req.wdata[0];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      modulo    <= ntm_cosh_pkg::data_width'(1);
      size      <= (ntm_cosh_pkg::index_width + 1)'(1);
      done_flag <= 1'b0;
    end else begin
      if (write_ok && is_modulo) begin
        modulo <= apb_req.wdata;
      end
      if (write_ok && is_size) begin
        size <= apb_req.wdata[ntm_cosh_pkg::index_width:0];
      end
      // Sticky until the next run
      if (start) begin
        done_flag <= 1'b0;
      end else if (done) begin
        done_flag <= 1'b1;
      end
    end
  end

  // Read mux
  always_comb begin
    prdata = '0;
    if (is_status) begin
      prdata[0] = busy;
      prdata[1] = done_flag | done;   // Visible in the same cycle busy drops
    end else if (is_modulo) begin
      prdata = modulo;
    end else if (is_size) begin
      prdata[ntm_cosh_pkg::index_width:0] = size;
    end else if (hit_out) begin
      prdata = host_out_data;
    end
  end

  // Error only ever follows a setup phase
  assert property (@(posedge CLK) disable iff (RST)
    pslverr |-> $past(apb_req.sel && !apb_req.enable));

endmodule

`default_nettype wire

//--- logic/ntm_cosh_top.sv
/* Vector cosh subsystem top */

`timescale 1ns/1ps
`default_nettype none

module ntm_cosh_top (
  input  logic                                CLK,
  input  logic                                RST,
  input  ntm_cosh_pkg::apb_req_t              apb_req,
  output logic [ntm_cosh_pkg::data_width-1:0] prdata,
  output logic                                pready,
  output logic                                pslverr
);

  // Host side
  ntm_cosh_pkg::buf_wr_t                host_in_wr;
  logic [ntm_cosh_pkg::index_width-1:0] host_out_index;
  logic [ntm_cosh_pkg::data_width-1:0]  host_out_data;

  // Run control
  logic                                 start;
  logic                                 busy;
  logic                                 done;
  logic [ntm_cosh_pkg::data_width-1:0]  modulo;
  logic [ntm_cosh_pkg::index_width:0]   size;

  // Sequencer side
  logic [ntm_cosh_pkg::index_width-1:0] seq_in_index;
  logic [ntm_cosh_pkg::data_width-1:0]  seq_in_data;
  ntm_cosh_pkg::buf_wr_t                seq_out_wr;

  ntm_apb_regs apb_regs_inst (
    .CLK            (CLK),
    .RST            (RST),
    .apb_req        (apb_req),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .host_in_wr     (host_in_wr),
    .host_out_index (host_out_index),
    .host_out_data  (host_out_data),
    .start          (start),
    .modulo         (modulo),
    .size           (size),
    .busy           (busy),
    .done           (done)
  );

  ntm_vector_buffer vector_buffer_inst (
    .CLK          (CLK),
    .in_wr        (host_in_wr),
    .in_rd_index  (seq_in_index),
    .in_rd_data   (seq_in_data),
    .out_wr       (seq_out_wr),
    .out_rd_index (host_out_index),
    .out_rd_data  (host_out_data)
  );

  ntm_vector_cosh_function vector_cosh_inst (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .modulo   (modulo),
    .size     (size),
    .busy     (busy),
    .done     (done),
    .in_index (seq_in_index),
    .in_data  (seq_in_data),
    .out_wr   (seq_out_wr)
  );

endmodule

`default_nettype wire

//--- testbench/ntm_cosh_tb_ref.svh
/* Cosh reference and APB host tasks */

`ifndef NTM_COSH_TB_REF_SVH
`define NTM_COSH_TB_REF_SVH

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Truncated series 1 + x^2/2 + x^4/24 in Q4.12, then mod m
  function automatic int unsigned cosh_ref(
    input logic [15:0] x,
    input logic [15:0] m
  );
    longint unsigned xl;
    longint unsigned t;
    longint unsigned q;
    longint unsigned y;
    xl = 64'(x);
    t  = (xl * xl) >> ntm_cosh_pkg::frac_bits;
    q  = ((t * t) >> ntm_cosh_pkg::frac_bits) / 24;
    // One in fixed point plus half the square plus the fourth term
    y  = (64'd1 << ntm_cosh_pkg::frac_bits) + (t >> 1) + q;
    return 32'(y % 64'(m));
  endfunction

  // Galois LFSR, x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'hD000_0001;
    end
    return n;
  endfunction

  //////////////////////////////
  // APB host
  //////////////////////////////

  // Setup, access, then back to idle
  task automatic write_word(
    input  logic [7:0]  addr,
    input  logic [15:0] data,
    output logic        err
  );
    @(negedge CLK);
    apb_req = '{sel: 1'b1, enable: 1'b0, write: 1'b1, addr: addr, wdata: data};
    @(negedge CLK);
    apb_req.enable = 1'b1;
    // Mid access phase, well clear of the rising edge
    #5;
    err = pslverr;
    @(negedge CLK);
    apb_req = '0;
  endtask

  task automatic read_word(
    input  logic [7:0]  addr,
    output logic [15:0] data,
    output logic        err
  );
    @(negedge CLK);
    apb_req = '{sel: 1'b1, enable: 1'b0, write: 1'b0, addr: addr, wdata: 16'h0};
    @(negedge CLK);
    apb_req.enable = 1'b1;
    #5;
    data = prdata;
    err  = pslverr;
    @(negedge CLK);
    apb_req = '0;
  endtask

`endif

//--- testbench/ntm_cosh_tb.sv
/* Vector cosh subsystem testbench */

`timescale 1ns/1ps
`default_nettype none

module ntm_cosh_tb;

  // 38 cycles per element, 16 elements, plus APB traffic
  localparam int num_runs       = 8;
  localparam int run_cycles     = 38 * 16 + 60;
  localparam int timeout_cycles = 5 * run_cycles * num_runs;

  logic                   CLK;
  logic                   RST;
  ntm_cosh_pkg::apb_req_t apb_req;
  logic [15:0]            prdata;
  logic                   pready;
  logic                   pslverr;

  logic [31:0] lfsr_state;
  int unsigned cycle_count;

  // What the host has programmed
  logic [15:0] model_in [16];
  logic [15:0] model_mod;
  int          model_size;

  // Pending checks
  string       name_q [$];
  int unsigned exp_q [$];
  int unsigned act_q [$];
  event        check_ev;
  int unsigned checks_done;
  string       cur_name;
  int unsigned cur_exp;
  int unsigned cur_act;

  logic [15:0] rd;
  logic        err;
  logic [31:0] rnd;

  `include "ntm_cosh_tb_ref.svh"

  ntm_cosh_top ntm_cosh_top_inst (
    .CLK     (CLK),
    .RST     (RST),
    .apb_req (apb_req),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #10 CLK = ~CLK;

  //////////////////////////////
  // Comparison and timeout
  //////////////////////////////

  always @(check_ev) begin
    while (act_q.size() > 0) begin
      cur_name = name_q.pop_front();
      cur_exp  = exp_q.pop_front();
      cur_act  = act_q.pop_front();
      assert (cur_act == cur_exp) else begin
        $display("MISMATCH %s expected 0x%0h actual 0x%0h", cur_name, cur_exp, cur_act);
        $display("Test failures found");
        $fatal(1);
      end
      checks_done++;
    end
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout after %0d cycles, a run never finished", cycle_count);
      $display("Test failures found");
      $fatal(1);
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic expect_value(input string name, input int unsigned exp, input int unsigned act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
    -> check_ev;
  endtask

  // Oldest bit first, one LFSR step per bit
  task automatic random_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic load_vector(input string name);
    logic e;
    write_word(ntm_cosh_pkg::reg_modulo, model_mod, e);
    expect_value({name, "_modulo_err"}, 0, e);
    write_word(ntm_cosh_pkg::reg_size, 16'(model_size), e);
    expect_value({name, "_size_err"}, 0, e);
    for (int i = 0; i < model_size; i++) begin
      write_word(ntm_cosh_pkg::in_base + 8'(4 * i), model_in[i], e);
      expect_value({name, "_in_err"}, 0, e);
    end
  endtask

  // START, then BUSY set and DONE cleared
  task automatic start_run(input string name);
    logic        e;
    logic [15:0] st;
    write_word(ntm_cosh_pkg::reg_ctrl, 16'h1, e);
    expect_value({name, "_start_err"}, 0, e);
    read_word(ntm_cosh_pkg::reg_status, st, e);
    expect_value({name, "_status_busy"}, 1, st);
  endtask

  // Poll until BUSY drops, DONE must be up
  task automatic wait_done(input string name);
    logic        e;
    logic [15:0] st;
    do begin
      read_word(ntm_cosh_pkg::reg_status, st, e);
    end while (st[0]);
    expect_value({name, "_status_done"}, 2, st);
  endtask

  task automatic check_results(input string name);
    logic        e;
    logic [15:0] r;
    for (int i = 0; i < model_size; i++) begin
      read_word(ntm_cosh_pkg::out_base + 8'(4 * i), r, e);
      expect_value($sformatf("%s_out%0d", name, i), cosh_ref(model_in[i], model_mod), r);
    end
  endtask

  task automatic run_vector(input string name);
    start_run(name);
    wait_done(name);
    check_results(name);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    CLK         = 1'b0;
    RST         = 1'b1;
    apb_req     = '0;
    lfsr_state  = 32'd98480;
    cycle_count = 0;
    checks_done = 0;
    for (int i = 0; i < 16; i++) begin
      model_in[i] = 16'h0;
    end
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Reset values
    read_word(ntm_cosh_pkg::reg_status, rd, err);
    expect_value("reset_status", 0, rd);
    expect_value("reset_status_err", 0, err);
    read_word(ntm_cosh_pkg::reg_modulo, rd, err);
    expect_value("reset_modulo", 1, rd);
    expect_value("reset_modulo_err", 0, err);
    read_word(ntm_cosh_pkg::reg_size, rd, err);
    expect_value("reset_size", 1, rd);
    expect_value("reset_size_err", 0, err);
    read_word(ntm_cosh_pkg::reg_ctrl, rd, err);
    expect_value("reset_ctrl_err", 0, err);
    expect_value("pready_high", 1, pready);

    // cosh(0) is one, 4096 in Q4.12
    model_mod  = 16'hFFFF;
    model_size = 1;
    load_vector("x_zero");
    start_run("x_zero");
    wait_done("x_zero");
    read_word(ntm_cosh_pkg::out_base, rd, err);
    expect_value("x_zero_out0", 4096, rd);

    model_in[0] = 16'd4096;
    load_vector("x_one");
    run_vector("x_one");

    // Random length and modulus
    for (int r = 0; r < 4; r++) begin
      random_bits(4, rnd);
      model_size = int'(rnd[3:0]) + 1;
      random_bits(16, rnd);
      model_mod = rnd[15:0];
      if (model_mod == 16'h0) begin
        model_mod = 16'h1;
      end
      for (int i = 0; i < 16; i++) begin
        random_bits(16, rnd);
        model_in[i] = rnd[15:0];
      end
      load_vector($sformatf("random_%0d", r));
      run_vector($sformatf("random_%0d", r));
    end

    // Refused accesses
    write_word(8'h10, 16'h1234, err);
    expect_value("unmapped_write_err", 1, err);
    read_word(8'h10, rd, err);
    expect_value("unmapped_read_err", 1, err);
    write_word(ntm_cosh_pkg::reg_modulo, 16'h0, err);
    expect_value("modulo_zero_err", 1, err);
    read_word(ntm_cosh_pkg::reg_modulo, rd, err);
    expect_value("modulo_kept", model_mod, rd);
    write_word(ntm_cosh_pkg::reg_size, 16'd17, err);
    expect_value("size_17_err", 1, err);
    read_word(ntm_cosh_pkg::reg_size, rd, err);
    expect_value("size_kept", model_size, rd);

    start_run("busy_refuse");
    write_word(ntm_cosh_pkg::in_base, ~model_in[0], err);
    expect_value("busy_in_write_err", 1, err);
    write_word(ntm_cosh_pkg::reg_ctrl, 16'h1, err);
    expect_value("busy_start_err", 1, err);
    wait_done("busy_refuse");
    check_results("busy_refuse");

    // Same inputs again
    run_vector("reuse");

    -> check_ev;
    @(negedge CLK);
    if (act_q.size() == 0 && checks_done > 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Checks were left pending at the end of the run");
      $display("Test failures found");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+testbench
logic/ntm_cosh_pkg.sv
logic/ntm_scalar_cosh_function.sv
logic/ntm_vector_buffer.sv
logic/ntm_vector_cosh_function.sv
logic/ntm_apb_regs.sv
logic/ntm_cosh_top.sv
testbench/ntm_cosh_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the vector cosh testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ntm_cosh_tb -f sources.f -o ntm_cosh_sim

output=$(./obj_dir/ntm_cosh_sim || true)
echo "$output"

echo "$output" | grep -qF "All tests passed!"
